// ==== include/fu_cfg.svh ====
`ifndef FU_CFG_SVH
`define FU_CFG_SVH

// Datapath width
`define FU_XLEN 64

// Reorder buffer, index wraps modulo the entry count
`define FU_NUM_ROB 32
`define FU_ROB_W $clog2(`FU_NUM_ROB)

// Physical register tag
`define FU_TAG_W 6

// Multiplier pipeline depth
`define FU_MULT_STAGES 4

// Multiplier bits retired per stage
`define FU_MULT_CHUNK (`FU_XLEN / `FU_MULT_STAGES)

// ALU immediate operand
`define FU_LIT_W 8

`endif

// ==== src/fu_pkg.sv ====
`default_nettype none

`include "fu_cfg.svh"

package fu_pkg;

  // Branch displacement in instruction words
  localparam int disp_w = 21;

  typedef enum logic [4:0] {
    alu_addq   = 5'h00,
    alu_subq   = 5'h01,
    alu_and    = 5'h02,
    alu_bic    = 5'h03,
    alu_bis    = 5'h04,
    alu_ornot  = 5'h05,
    alu_xor    = 5'h06,
    alu_eqv    = 5'h07,
    alu_srl    = 5'h08,
    alu_sll    = 5'h09,
    alu_sra    = 5'h0a,
    alu_cmpult = 5'h0b,
    alu_cmpeq  = 5'h0c,
    alu_cmpule = 5'h0d,
    alu_cmplt  = 5'h0e,
    alu_cmple  = 5'h0f,
    alu_mulq   = 5'h10  // Multiplier only
  } alu_func_e;

  typedef enum logic {
    opb_is_reg = 1'b0,
    opb_is_lit = 1'b1
  } opb_sel_e;

  // Bit 2 inverts the base test
  typedef enum logic [2:0] {
    br_blbc = 3'd0,
    br_beq  = 3'd1,
    br_blt  = 3'd2,
    br_ble  = 3'd3,
    br_blbs = 3'd4,
    br_bne  = 3'd5,
    br_bge  = 3'd6,
    br_bgt  = 3'd7
  } br_cond_e;

  typedef struct packed {
    logic                      valid;
    alu_func_e                 func;
    opb_sel_e                  opb_sel;
    br_cond_e                  br_cond;
    logic                      cond_branch;
    logic                      uncond_branch;
    logic [`FU_ROB_W-1:0]      rob_idx;
    logic [`FU_TAG_W-1:0]      tag;
    logic [`FU_XLEN-1:0]       opa;
    logic [`FU_XLEN-1:0]       opb;
    logic [`FU_LIT_W-1:0]      lit;
    logic [`FU_XLEN-1:0]       npc;
    logic signed [disp_w-1:0]  disp;
  } fu_issue_t;

  typedef struct packed {
    logic                 valid;
    logic [`FU_ROB_W-1:0] rob_idx;
    logic [`FU_TAG_W-1:0] tag;
    logic [`FU_XLEN-1:0]  value;
  } fu_result_t;

  typedef struct packed {
    logic                 valid;
    logic [`FU_ROB_W-1:0] rob_idx;  // Entry of the branch itself
    logic [`FU_XLEN-1:0]  target;
  } rollback_t;

  // Younger than the branch and not past the ROB tail
  function automatic logic is_squashed(rollback_t rb, logic [`FU_ROB_W-1:0] rob_tail,
                                       logic [`FU_ROB_W-1:0] rob_idx);
    logic [`FU_ROB_W-1:0] entry_dist;
    logic [`FU_ROB_W-1:0] tail_dist;
    entry_dist = rob_idx - rb.rob_idx;   // Wraps modulo ROB size
    tail_dist  = rob_tail - rb.rob_idx;
    return rb.valid && (entry_dist != '0) && (entry_dist <= tail_dist);
  endfunction

endpackage

`default_nettype wire

// ==== src/alu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fu_cfg.svh"

module alu_unit (
  input  logic                 clock,
  input  logic                 reset,
  input  fu_pkg::fu_issue_t    issue,
  input  fu_pkg::rollback_t    rollback,
  input  logic [`FU_ROB_W-1:0] rob_tail,
  output fu_pkg::fu_result_t   result
);

  logic [`FU_XLEN-1:0]  opa;
  logic [`FU_XLEN-1:0]  opb;
  logic [`FU_XLEN-1:0]  value;
  logic [`FU_XLEN-1:0]  sign_fill;
  logic [5:0]           shamt;
  logic                 ult;
  logic                 slt;
  logic                 eq;
  logic                 valid_q;
  logic [`FU_ROB_W-1:0] rob_idx_q;
  logic [`FU_TAG_W-1:0] tag_q;
  logic [`FU_XLEN-1:0]  value_q;

  assign opa   = issue.opa;
  assign opb   = (issue.opb_sel == fu_pkg::opb_is_lit) ?
                 {{(`FU_XLEN-`FU_LIT_W){1'b0}}, issue.lit} : issue.opb;
  assign shamt = opb[5:0];

  // Upper bits vacated by the logical shift
  assign sign_fill = {`FU_XLEN{opa[`FU_XLEN-1]}} & ~({`FU_XLEN{1'b1}} >> shamt);

  assign ult = opa < opb;
  assign eq  = opa == opb;
  // Differing signs decide on their own
  assign slt = (opa[`FU_XLEN-1] != opb[`FU_XLEN-1]) ? opa[`FU_XLEN-1] : ult;

  always_comb begin
    case (issue.func)
      fu_pkg::alu_addq:   value = opa + opb;
      fu_pkg::alu_subq:   value = opa - opb;
      fu_pkg::alu_and:    value = opa & opb;
      fu_pkg::alu_bic:    value = opa & ~opb;
      fu_pkg::alu_bis:    value = opa | opb;
      fu_pkg::alu_ornot:  value = opa | ~opb;
      fu_pkg::alu_xor:    value = opa ^ opb;
      fu_pkg::alu_eqv:    value = opa ^ ~opb;
      fu_pkg::alu_srl:    value = opa >> shamt;
      fu_pkg::alu_sll:    value = opa << shamt;
      fu_pkg::alu_sra:    value = (opa >> shamt) | sign_fill;
      fu_pkg::alu_cmpult: value = {{(`FU_XLEN-1){1'b0}}, ult};
      fu_pkg::alu_cmpeq:  value = {{(`FU_XLEN-1){1'b0}}, eq};
      fu_pkg::alu_cmpule: value = {{(`FU_XLEN-1){1'b0}}, ult | eq};
      fu_pkg::alu_cmplt:  value = {{(`FU_XLEN-1){1'b0}}, slt};
      fu_pkg::alu_cmple:  value = {{(`FU_XLEN-1){1'b0}}, slt | eq};
      default:            value = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue.valid &&
                 !fu_pkg::is_squashed(rollback, rob_tail, issue.rob_idx);
    end
  end

  always_ff @(posedge clock) begin
    rob_idx_q <= issue.rob_idx;
    tag_q     <= issue.tag;
    value_q   <= value;
  end

  assign result = '{valid: valid_q, rob_idx: rob_idx_q, tag: tag_q, value: value_q};

  // Issue logic steers multiplies elsewhere
  a_no_mulq: assert property (@(posedge clock) disable iff (reset)
    issue.valid |-> issue.func != fu_pkg::alu_mulq);

endmodule

`default_nettype wire

// ==== src/mult_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fu_cfg.svh"

// Stage record type comes from the instantiating pipeline
module mult_stage #(
  parameter type mult_stage_t = logic
) (
  input  logic                 clock,
  input  logic                 reset,
  input  mult_stage_t          stage_in,
  input  fu_pkg::rollback_t    rollback,
  input  logic [`FU_ROB_W-1:0] rob_tail,
  output mult_stage_t          stage_out
);

  logic [`FU_XLEN-1:0] partial_product;
  mult_stage_t         stage_next;
  mult_stage_t         data_q;
  logic                valid_q;

  // Low chunk of the multiplier against the full multiplicand
  assign partial_product = stage_in.mplier[`FU_MULT_CHUNK-1:0] * stage_in.mcand;

  always_comb begin
    stage_next         = stage_in;
    stage_next.product = stage_in.product + partial_product;
    stage_next.mplier  = stage_in.mplier >> `FU_MULT_CHUNK;
    stage_next.mcand   = stage_in.mcand << `FU_MULT_CHUNK;
    // Younger than a taken branch, never reaches the next register
    stage_next.valid   = stage_in.valid &&
                         !fu_pkg::is_squashed(rollback, rob_tail, stage_in.rob_idx);
  end

  // Contents move on every edge, so a squashed entry here is
  // dropped as it enters the next stage
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= stage_next.valid;
    end
  end

  always_ff @(posedge clock) begin
    data_q <= stage_next;
  end

  always_comb begin
    stage_out       = data_q;
    stage_out.valid = valid_q;
  end

endmodule

`default_nettype wire

// ==== src/mult_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fu_cfg.svh"

module mult_pipe (
  input  logic                 clock,
  input  logic                 reset,
  input  fu_pkg::fu_issue_t    issue,
  input  fu_pkg::rollback_t    rollback,
  input  logic [`FU_ROB_W-1:0] rob_tail,
  output fu_pkg::fu_result_t   result
);

  typedef struct packed {
    logic                 valid;
    logic [`FU_ROB_W-1:0] rob_idx;
    logic [`FU_TAG_W-1:0] tag;
    logic [`FU_XLEN-1:0]  product;  // Running sum of partial products
    logic [`FU_XLEN-1:0]  mplier;
    logic [`FU_XLEN-1:0]  mcand;
  } mult_stage_t;

  mult_stage_t chain [`FU_MULT_STAGES+1];
  mult_stage_t last;

  always_comb begin
    chain[0].valid   = issue.valid;
    chain[0].rob_idx = issue.rob_idx;
    chain[0].tag     = issue.tag;
    chain[0].product = '0;
    chain[0].mplier  = issue.opa;
    chain[0].mcand   = (issue.opb_sel == fu_pkg::opb_is_lit) ?
                       {{(`FU_XLEN-`FU_LIT_W){1'b0}}, issue.lit} : issue.opb;
  end

  for (genvar k = 0; k < `FU_MULT_STAGES; k++) begin : g_stage
    mult_stage #(
      .mult_stage_t (mult_stage_t)
    ) stage_inst (
      .clock     (clock),
      .reset     (reset),
      .stage_in  (chain[k]),
      .rollback  (rollback),
      .rob_tail  (rob_tail),
      .stage_out (chain[k+1])
    );
  end

  assign last = chain[`FU_MULT_STAGES];

  // Final register can still be hit by a rollback in its strobe cycle
  always_comb begin
    result.valid   = last.valid && !fu_pkg::is_squashed(rollback, rob_tail, last.rob_idx);
    result.rob_idx = last.rob_idx;
    result.tag     = last.tag;
    result.value   = last.product;
  end

  a_mulq_only: assert property (@(posedge clock) disable iff (reset)
    issue.valid |-> issue.func == fu_pkg::alu_mulq);

endmodule

`default_nettype wire

// ==== src/branch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fu_cfg.svh"

module branch_unit (
  input  logic               clock,
  input  logic               reset,
  input  fu_pkg::fu_issue_t  issue,
  output fu_pkg::fu_result_t result,
  output fu_pkg::rollback_t  rollback
);

  logic [`FU_XLEN-1:0]  disp_ext;
  logic [`FU_XLEN-1:0]  target;
  logic                 test_true;
  logic                 taken;
  logic                 result_valid_q;
  logic                 rollback_valid_q;
  logic [`FU_ROB_W-1:0] rob_idx_q;
  logic [`FU_TAG_W-1:0] tag_q;
  logic [`FU_XLEN-1:0]  npc_q;
  logic [`FU_XLEN-1:0]  target_q;

  always_comb begin
    case (issue.br_cond)
      fu_pkg::br_blbc, fu_pkg::br_blbs: test_true = ~issue.opa[0];
      fu_pkg::br_beq,  fu_pkg::br_bne:  test_true = issue.opa == '0;
      fu_pkg::br_blt,  fu_pkg::br_bge:  test_true = issue.opa[`FU_XLEN-1];
      default:                          test_true = issue.opa[`FU_XLEN-1] || issue.opa == '0;
    endcase
    if (issue.br_cond[2]) begin
      test_true = ~test_true;  // Negated forms
    end
  end

  assign taken = issue.uncond_branch || (issue.cond_branch && test_true);

  // Word displacement to byte offset
  assign disp_ext = {{(`FU_XLEN-fu_pkg::disp_w-2){issue.disp[fu_pkg::disp_w-1]}},
                     issue.disp, 2'b00};
  assign target   = issue.npc + disp_ext;

  always_ff @(posedge clock) begin
    if (reset) begin
      result_valid_q   <= 1'b0;
      rollback_valid_q <= 1'b0;
    end else begin
      result_valid_q   <= issue.valid;
      rollback_valid_q <= issue.valid && taken;
    end
  end

  always_ff @(posedge clock) begin
    rob_idx_q <= issue.rob_idx;
    tag_q     <= issue.tag;
    npc_q     <= issue.npc;   // Link value
    target_q  <= target;
  end

  assign result   = '{valid: result_valid_q, rob_idx: rob_idx_q, tag: tag_q, value: npc_q};
  assign rollback = '{valid: rollback_valid_q, rob_idx: rob_idx_q, target: target_q};

  // A branch is either conditional or unconditional, never both
  a_one_branch_kind: assert property (@(posedge clock) disable iff (reset)
    issue.valid |-> issue.cond_branch ^ issue.uncond_branch);

endmodule

`default_nettype wire

// ==== src/exec_units.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fu_cfg.svh"

module exec_units (
  input  logic                 clock,
  input  logic                 reset,
  input  fu_pkg::fu_issue_t    alu_issue,
  input  fu_pkg::fu_issue_t    mult_issue,
  input  fu_pkg::fu_issue_t    br_issue,
  input  logic [`FU_ROB_W-1:0] rob_tail,
  output fu_pkg::fu_result_t   alu_result,
  output fu_pkg::fu_result_t   mult_result,
  output fu_pkg::fu_result_t   br_result,
  output fu_pkg::rollback_t    rollback
);

  // Branch outcome drives the squash in both other units
  branch_unit branch_inst (
    .clock    (clock),
    .reset    (reset),
    .issue    (br_issue),
    .result   (br_result),
    .rollback (rollback)
  );

  alu_unit alu_inst (
    .clock    (clock),
    .reset    (reset),
    .issue    (alu_issue),
    .rollback (rollback),
    .rob_tail (rob_tail),
    .result   (alu_result)
  );

  mult_pipe mult_inst (
    .clock    (clock),
    .reset    (reset),
    .issue    (mult_issue),
    .rollback (rollback),
    .rob_tail (rob_tail),
    .result   (mult_result)
  );

endmodule

`default_nettype wire

// ==== verif/exec_units_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fu_cfg.svh"

module exec_units_tb;

  typedef struct {
    int                   unit;  // 0 alu, 1 mult, 2 branch
    fu_pkg::alu_func_e    func;
    logic [`FU_XLEN-1:0]  opa;
    logic [`FU_XLEN-1:0]  opb;
    logic [7:0]           lit;
    logic                 use_lit;
    fu_pkg::br_cond_e     cond;
    logic                 cond_br;
    logic                 uncond;
    logic [`FU_XLEN-1:0]  exp;
  } row_t;

  localparam int timeout = 20;

  logic                 clock;
  logic                 reset;
  fu_pkg::fu_issue_t    alu_issue;
  fu_pkg::fu_issue_t    mult_issue;
  fu_pkg::fu_issue_t    br_issue;
  logic [`FU_ROB_W-1:0] rob_tail;
  fu_pkg::fu_result_t   alu_result;
  fu_pkg::fu_result_t   mult_result;
  fu_pkg::fu_result_t   br_result;
  fu_pkg::rollback_t    rollback;
  row_t                 rows[$];
  int                   errors;
  int                   tests;

  exec_units exec_units_inst (
    .clock       (clock),
    .reset       (reset),
    .alu_issue   (alu_issue),
    .mult_issue  (mult_issue),
    .br_issue    (br_issue),
    .rob_tail    (rob_tail),
    .alu_result  (alu_result),
    .mult_result (mult_result),
    .br_result   (br_result),
    .rollback    (rollback)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [63:0] alu_model(fu_pkg::alu_func_e f, logic [63:0] a,
                                            logic [63:0] b);
    case (f)
      fu_pkg::alu_addq:   return a + b;
      fu_pkg::alu_subq:   return a - b;
      fu_pkg::alu_and:    return a & b;
      fu_pkg::alu_bic:    return a & ~b;
      fu_pkg::alu_bis:    return a | b;
      fu_pkg::alu_ornot:  return a | ~b;
      fu_pkg::alu_xor:    return a ^ b;
      fu_pkg::alu_eqv:    return ~(a ^ b);
      fu_pkg::alu_srl:    return a >> b[5:0];
      fu_pkg::alu_sll:    return a << b[5:0];
      fu_pkg::alu_sra:    return $signed(a) >>> b[5:0];
      fu_pkg::alu_cmpult: return {63'd0, a < b};
      fu_pkg::alu_cmpeq:  return {63'd0, a == b};
      fu_pkg::alu_cmpule: return {63'd0, a <= b};
      fu_pkg::alu_cmplt:  return {63'd0, $signed(a) < $signed(b)};
      fu_pkg::alu_cmple:  return {63'd0, $signed(a) <= $signed(b)};
      default:            return a * b;  // mulq
    endcase
  endfunction

  function automatic logic taken_model(row_t r);
    logic [63:0] a;
    a = r.opa;
    if (r.uncond) return 1'b1;
    if (!r.cond_br) return 1'b0;
    case (r.cond)
      fu_pkg::br_blbc: return a[0] == 1'b0;
      fu_pkg::br_beq:  return a == 0;
      fu_pkg::br_blt:  return $signed(a) < 0;
      fu_pkg::br_ble:  return $signed(a) <= 0;
      fu_pkg::br_blbs: return a[0] == 1'b1;
      fu_pkg::br_bne:  return a != 0;
      fu_pkg::br_bge:  return $signed(a) >= 0;
      default:         return $signed(a) > 0;
    endcase
  endfunction

  function automatic fu_pkg::fu_issue_t make_issue(row_t r, logic [4:0] rob, int n);
    fu_pkg::fu_issue_t iss;
    iss = '0;
    iss.valid = 1'b1;
    iss.func = r.func;
    iss.opb_sel = r.use_lit ? fu_pkg::opb_is_lit : fu_pkg::opb_is_reg;
    iss.br_cond = r.cond;
    iss.cond_branch = r.cond_br;
    iss.uncond_branch = r.uncond;
    iss.rob_idx = rob;
    iss.tag = n[5:0];
    iss.opa = r.opa;
    iss.opb = r.opb;
    iss.lit = r.lit;
    iss.npc = 64'h1000 + 64'(n * 4);
    iss.disp = (n % 2) ? -21'sd3 - n : 21'sd7 + n;
    return iss;
  endfunction

  task automatic add_row(int unit, fu_pkg::alu_func_e f, logic [63:0] a, logic [63:0] b,
                         logic use_lit, logic [63:0] exp);
    row_t r;
    r = '{unit: unit, func: f, opa: a, opb: b, lit: b[7:0], use_lit: use_lit,
          cond: fu_pkg::br_beq, cond_br: 1'b0, uncond: 1'b0, exp: exp};
    rows.push_back(r);
  endtask

  task automatic check_result(string name, fu_pkg::fu_result_t got, fu_pkg::fu_result_t exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_rollback(string name, fu_pkg::rollback_t got, fu_pkg::rollback_t exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_latency(string name, int got, int exp);
    if (got != exp) begin
      $display("ERR t=%0t %s got %0d exp %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic clear_issues();
    alu_issue  = '0;
    mult_issue = '0;
    br_issue   = '0;
  endtask

  // Called on a falling edge, returns on the falling edge of the strobe
  task automatic run_row(row_t r, int n);
    fu_pkg::fu_issue_t  iss;
    fu_pkg::fu_result_t got;
    fu_pkg::fu_result_t exp;
    fu_pkg::rollback_t  rb_exp;
    fu_pkg::rollback_t  rb_got;
    int                 cycles;
    int                 err0;
    err0 = errors;
    iss = make_issue(r, 5'd4, n);
    rob_tail = 5'd10;
    if (r.unit == 0) alu_issue = iss;
    else if (r.unit == 1) mult_issue = iss;
    else br_issue = iss;
    cycles = 0;
    got = '0;
    while (!got.valid && cycles < timeout) begin
      @(negedge clock);
      cycles++;
      clear_issues();
      got = (r.unit == 0) ? alu_result : (r.unit == 1) ? mult_result : br_result;
    end
    exp = '{valid: 1'b1, rob_idx: iss.rob_idx, tag: iss.tag, value: r.exp};
    if (!got.valid) begin
      $display("row %0d: no result strobe within timeout", n);
      errors++;
    end else begin
      check_latency("latency", cycles, (r.unit == 1) ? `FU_MULT_STAGES : 1);
      check_result(r.unit == 0 ? "alu_result" : r.unit == 1 ? "mult_result" : "br_result",
                   got, exp);
      if (r.unit == 2) begin
        rb_exp = '0;
        rb_got = rollback;
        if (taken_model(r)) begin
          rb_exp = '{valid: 1'b1, rob_idx: iss.rob_idx,
                     target: iss.npc + (64'($signed(iss.disp)) << 2)};
        end else begin
          rb_got.rob_idx = '0;  // Payload means nothing without valid
          rb_got.target  = '0;
        end
        check_rollback("rollback", rb_got, rb_exp);
      end
    end
    tests++;
    $display("row %0d unit %0d %s: %s", n, r.unit, r.func.name(),
             errors == err0 ? "ok" : "bad");
  endtask

  // Collects mult strobes for a while after a squash sequence
  task automatic collect_mults(int cycles_max, output int seen[$]);
    seen = {};
    for (int c = 0; c < cycles_max; c++) begin
      @(negedge clock);
      clear_issues();
      if (mult_result.valid) seen.push_back(mult_result.rob_idx);
    end
  endtask

  initial begin
    row_t               r;
    logic [63:0]        edge_vals [3];
    logic [63:0]        exp_q [$];
    int                 issue_at [$];
    int                 seen [$];
    fu_pkg::fu_result_t mexp;
    fu_pkg::fu_result_t aexp;
    logic               early_strobe;
    errors = 0;
    tests = 0;
    void'($urandom(32'h8283_60b1));
    clear_issues();
    rob_tail = '0;
    reset = 1'b1;
    for (int c = 0; c < 4; c++) begin
      @(negedge clock);
      if (alu_result.valid || mult_result.valid || br_result.valid || rollback.valid) begin
        $display("valid output strobed during reset");
        errors++;
      end
    end
    reset = 1'b0;

    add_row(0, fu_pkg::alu_addq, 64'd5, 64'd7, 1'b0, 64'd12);
    add_row(0, fu_pkg::alu_subq, 64'd3, 64'd5, 1'b0, 64'hffff_ffff_ffff_fffe);
    add_row(0, fu_pkg::alu_sra, 64'h8000_0000_0000_0000, 64'd4, 1'b1, 64'hf800_0000_0000_0000);
    add_row(0, fu_pkg::alu_srl, 64'h8000_0000_0000_0000, 64'd4, 1'b0, 64'h0800_0000_0000_0000);
    add_row(0, fu_pkg::alu_cmpult, 64'd1, '1, 1'b0, 64'd1);
    add_row(0, fu_pkg::alu_cmplt, 64'd1, '1, 1'b0, 64'd0);
    add_row(0, fu_pkg::alu_cmple, '1, 64'd1, 1'b0, 64'd1);
    add_row(0, fu_pkg::alu_cmpule, '1, 64'd1, 1'b0, 64'd0);
    add_row(0, fu_pkg::alu_cmpeq, 64'd42, 64'h2a, 1'b1, 64'd1);
    add_row(0, fu_pkg::alu_bic, 64'hff, 64'h0f, 1'b0, 64'hf0);
    // Every function, register and literal B, random operands
    for (int f = 0; f < 16; f++) begin
      for (int l = 0; l < 2; l++) begin
        r.opa = {$urandom, $urandom};
        r.opb = {$urandom, $urandom};
        if (l) r.opb = {56'd0, r.opb[7:0]};
        add_row(0, fu_pkg::alu_func_e'(f), r.opa, r.opb, l[0],
                alu_model(fu_pkg::alu_func_e'(f), r.opa, r.opb));
      end
    end
    edge_vals = '{64'd0, '1, 64'h8000_0000_0000_0000};
    for (int i = 0; i < 6; i++) begin
      r.opa = (i < 3) ? edge_vals[i] : {$urandom, $urandom};
      r.opb = (i == 2) ? '1 : {$urandom, $urandom};
      add_row(1, fu_pkg::alu_mulq, r.opa, r.opb, 1'b0, r.opa * r.opb);
    end
    add_row(1, fu_pkg::alu_mulq, 64'h1234_5678_9abc_def0, 64'h5a, 1'b1,
            64'h1234_5678_9abc_def0 * 64'h5a);
    edge_vals = '{64'd0, 64'hffff_ffff_ffff_fff6, 64'd7};
    for (int c = 0; c < 8; c++) begin
      for (int v = 0; v < 4; v++) begin
        add_row(2, fu_pkg::alu_addq, (v < 3) ? edge_vals[v] : 64'd8, 64'd0, 1'b0, '0);
        rows[$].cond = fu_pkg::br_cond_e'(c);
        rows[$].cond_br = 1'b1;
      end
    end
    add_row(2, fu_pkg::alu_addq, 64'd3, 64'd0, 1'b0, '0);
    rows[$].uncond = 1'b1;
    foreach (rows[i]) begin
      if (rows[i].unit == 2) rows[i].exp = 64'h1000 + 64'(i * 4);  // npc link
    end

    @(negedge clock);
    tests++;
    if (alu_result.valid || mult_result.valid || br_result.valid || rollback.valid) begin
      $display("valid output strobed right after reset");
      errors++;
    end
    $display("reset: done");
    foreach (rows[i]) run_row(rows[i], i);

    // Back to back multiplies, each expected exactly four cycles later
    edge_vals = '{64'd0, '1, 64'h8000_0000_0000_0000};
    for (int c = 0; c < 5 + timeout; c++) begin
      if (mult_result.valid) begin
        if (exp_q.size() == 0) begin
          $display("unexpected multiplier strobe");
          errors++;
        end else begin
          mexp = '{valid: 1'b1, rob_idx: 5'(issue_at[0]), tag: 6'(issue_at[0]),
                   value: exp_q.pop_front()};
          check_latency("mult_latency", c - issue_at.pop_front(), `FU_MULT_STAGES);
          check_result("mult_result", mult_result, mexp);
        end
      end
      clear_issues();
      if (c < 5) begin
        r.opa = (c < 3) ? edge_vals[c] : {$urandom, $urandom};
        r.opb = (c == 0) ? 64'h8000_0000_0000_0000 : {$urandom, $urandom};
        r.func = fu_pkg::alu_mulq;
        r.use_lit = 1'b0;
        mult_issue = make_issue(r, 5'(c), c);
        exp_q.push_back(r.opa * r.opb);
        issue_at.push_back(c);
      end
      @(negedge clock);
    end
    tests++;
    if (exp_q.size() != 0) begin
      $display("mult stream: no result strobe within timeout");
      errors++;
    end
    $display("mult stream: done");

    // Branch at 30, tail wraps to 3; 28 and 29 are older
    rob_tail = 5'd3;
    r.func = fu_pkg::alu_mulq;
    r.opa = 64'd6;
    r.opb = 64'd7;
    r.use_lit = 1'b0;
    mult_issue = make_issue(r, 5'd31, 1);
    @(negedge clock);
    mult_issue = make_issue(r, 5'd28, 2);
    @(negedge clock);
    mult_issue = make_issue(r, 5'd1, 3);
    @(negedge clock);
    mult_issue = make_issue(r, 5'd29, 4);
    r.uncond = 1'b1;
    r.cond_br = 1'b0;
    br_issue = make_issue(r, 5'd30, 5);
    @(negedge clock);
    clear_issues();
    // Younger issue in the rollback cycle, while 31 sits in the last stage
    mult_issue = make_issue(r, 5'd2, 6);
    early_strobe = mult_result.valid;
    collect_mults(timeout, seen);
    tests++;
    if (early_strobe || seen.size() != 2 || seen[0] != 28 || seen[1] != 29) begin
      $display("mult squash: wrong set of surviving multiplies, %0d strobes", seen.size());
      errors++;
    end
    $display("mult squash: done");

    // ALU issue in the rollback cycle, younger then older
    for (int k = 0; k < 2; k++) begin
      rob_tail = 5'd9;
      br_issue = make_issue(r, 5'd5, 6);
      @(negedge clock);
      clear_issues();
      r.func = fu_pkg::alu_addq;
      alu_issue = make_issue(r, k ? 5'd3 : 5'd7, 7);
      if (!rollback.valid) begin
        $display("alu squash: rollback missing");
        errors++;
      end
      @(negedge clock);
      clear_issues();
      r.func = fu_pkg::alu_mulq;
      tests++;
      if (alu_result.valid != k[0]) begin
        $display("ERR t=%0t alu_result.valid got %b exp %b", $time, alu_result.valid, k[0]);
        errors++;
      end else if (k == 1) begin
        aexp = '{valid: 1'b1, rob_idx: 5'd3, tag: 6'd7,
                 value: alu_model(fu_pkg::alu_addq, r.opa, r.opb)};
        check_result("alu_result", alu_result, aexp);
      end
      $display("alu squash %s: done", k ? "older" : "younger");
    end

    $display("tests %0d errors %0d", tests, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== exec_units.f ====
+incdir+include
src/fu_pkg.sv
src/alu_unit.sv
src/mult_stage.sv
src/mult_pipe.sv
src/branch_unit.sv
src/exec_units.sv
verif/exec_units_tb.sv

// ==== Bender.yml ====
package:
  name: exec_units

sources:
  - include_dirs:
      - include
    files:
      - src/fu_pkg.sv
      - src/alu_unit.sv
      - src/mult_stage.sv
      - src/mult_pipe.sv
      - src/branch_unit.sv
      - src/exec_units.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/exec_units_tb.sv
